//--- hw/accel_log_pkg.sv
////////////////////
// shared types for the accelerometer logger
// imported by wildcard into each module header
////////////////////
`default_nettype none

package accel_log_pkg;

  typedef logic [7:0]  byte_t;     // spi and memory byte
  typedef logic [15:0] sync_cnt_t; // sync strobes per pps interval

  // spi master states
  typedef enum logic [1:0] {
    st_idle,   // waiting for sync
    st_cmd,    // shifting out command byte
    st_data,   // shifting in data bytes
    st_finish  // csn release
  } spi_state_t;

  // sensor side spi outputs
  typedef struct packed {
    logic csn;  // active low select
    logic sclk; // mode 3, idles high
    logic mosi;
  } spi_pins_t;

  // sync generator status, 18 bits
  typedef struct packed {
    logic      pps_valid;  // last interval within tolerance
    logic      locked;     // last two intervals valid
    sync_cnt_t sync_count; // strobes in last interval
  } sync_status_t;

endpackage

`default_nettype wire

//--- hw/sync_gen.sv
////////////////////
// sample strobe generator from a phase accumulator
// pps rising edge restarts the phase when the interval is valid
// also counts strobes per pps interval
////////////////////
`timescale 1ns/1ps
`default_nettype none

module sync_gen import accel_log_pkg::*; #(
  parameter int clk_hz     = 40_000_000,
  parameter int sync_hz    = 1000,
  parameter int pps_period = 40_000_000,
  parameter int pps_tol    = 20_000,
  parameter int pa_bits    = 30
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         pps,
  output logic         sync,
  output sync_status_t status
);

  // step = sync_hz * 2^pa_bits / clk_hz, computed wide
  localparam longint unsigned step_wide = (64'(sync_hz) << pa_bits) / 64'(clk_hz);
  localparam logic [pa_bits-1:0] step = step_wide[pa_bits-1:0];

  // interval counter saturates just past the upper limit
  localparam int ivl_max = pps_period + pps_tol + 1;
  localparam int ivl_w   = $clog2(ivl_max + 1);
  localparam logic [ivl_w-1:0] ivl_lo  = ivl_w'(pps_period - pps_tol);
  localparam logic [ivl_w-1:0] ivl_hi  = ivl_w'(pps_period + pps_tol);
  localparam logic [ivl_w-1:0] ivl_sat = ivl_w'(ivl_max);

  logic [pa_bits-1:0] acc;      // phase
  logic [pa_bits:0]   acc_sum;  // with carry
  logic               wrap;
  logic [2:0]         pps_sr;   // 2-flop sync plus edge history
  logic               pps_rise;
  logic [ivl_w-1:0]   ivl_cnt;  // clocks since last edge
  logic               in_range;
  sync_cnt_t          run_cnt;  // strobes in current interval

  assign acc_sum  = {1'b0, acc} + {1'b0, step};
  assign wrap     = acc_sum[pa_bits]; // accumulator overflow
  assign pps_rise = pps_sr[1] & ~pps_sr[2];
  assign in_range = (ivl_cnt >= ivl_lo) && (ivl_cnt <= ivl_hi);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      acc     <= '0;
      sync    <= 1'b0;
      pps_sr  <= '0;
      ivl_cnt <= '0;
      run_cnt <= '0;
      status  <= '0;
    end
    else
    begin
      pps_sr <= {pps_sr[1:0], pps};
      sync   <= wrap; // strobe on cycle after wrap

      if (pps_rise && in_range)
        acc <= '0; // realign phase
      else
        acc <= acc_sum[pa_bits-1:0];

      if (pps_rise)
      begin
        ivl_cnt          <= ivl_w'(1);
        status.pps_valid <= in_range;
        status.locked    <= in_range & status.pps_valid;
        status.sync_count <= run_cnt;
        run_cnt          <= wrap ? sync_cnt_t'(1) : '0; // wrap counts to new interval
      end
      else
      begin
        if (ivl_cnt != ivl_sat)
          ivl_cnt <= ivl_cnt + 1'b1; // saturate on missing pps
        if (wrap)
          run_cnt <= run_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/accel_spi_reader.sv
////////////////////
// spi master for the accelerometer, mode 3
// one command byte then data_len bytes per accepted sync
// keeps first two bytes of every three
////////////////////
`timescale 1ns/1ps
`default_nettype none

module accel_spi_reader import accel_log_pkg::*; #(
  parameter byte_t cmd      = 8'h11, // read xyz
  parameter int    data_len = 9      // multiple of 3
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      sync,
  input  logic      miso,
  output spi_pins_t pins,
  output logic      busy,
  output logic      wr_en,
  output byte_t     wr_data
);

  localparam int cnt_w = $clog2(data_len + 1);

  spi_state_t       state;
  logic             csn;
  logic             sclk;
  logic             mosi;
  logic [2:0]       bit_cnt;   // bit within byte, also finish phase
  logic [cnt_w-1:0] byte_cnt;  // data byte index
  logic [1:0]       grp;       // position in 3-byte axis group
  byte_t            shift_out; // command shifter
  byte_t            shift_in;  // miso shifter
  logic             keep_pend; // kept byte completed last cycle

  assign pins = '{csn: csn, sclk: sclk, mosi: mosi};
  assign busy = (state != st_idle);

  // payload registers
  always_ff @(posedge clk)
  begin
    if (state == st_idle && sync)
      shift_out <= cmd;
    else if (state == st_cmd && sclk)
      shift_out <= {shift_out[6:0], 1'b0}; // msb first on falling edge
    if (state == st_data && !sclk)
      shift_in <= {shift_in[6:0], miso}; // sample on rising edge
    if (keep_pend)
      wr_data <= shift_in;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= st_idle;
      csn       <= 1'b1;
      sclk      <= 1'b1;
      mosi      <= 1'b0;
      bit_cnt   <= '0;
      byte_cnt  <= '0;
      grp       <= '0;
      keep_pend <= 1'b0;
      wr_en     <= 1'b0;
    end
    else
    begin
      keep_pend <= 1'b0;
      wr_en     <= keep_pend; // one cycle after last bit

      case (state)
        st_idle:
        begin
          if (sync) // strobes while busy are dropped
          begin
            state    <= st_cmd;
            csn      <= 1'b0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            grp      <= '0;
          end
        end

        st_cmd:
        begin
          sclk <= ~sclk;
          if (sclk)
            mosi <= shift_out[7];
          else if (bit_cnt == 3'd7)
          begin
            state   <= st_data;
            bit_cnt <= '0;
          end
          else
            bit_cnt <= bit_cnt + 1'b1;
        end

        st_data:
        begin
          sclk <= ~sclk;
          if (sclk)
            mosi <= 1'b0; // idle data out
          else if (bit_cnt == 3'd7)
          begin
            bit_cnt   <= '0;
            keep_pend <= (grp != 2'd2); // drop third byte
            grp       <= (grp == 2'd2) ? 2'd0 : grp + 1'b1;
            if (byte_cnt == cnt_w'(data_len - 1))
              state <= st_finish;
            else
              byte_cnt <= byte_cnt + 1'b1;
          end
          else
            bit_cnt <= bit_cnt + 1'b1;
        end

        st_finish:
        begin
          if (bit_cnt == 3'd0)
          begin
            csn     <= 1'b1; // one cycle high before idle
            bit_cnt <= 3'd1;
          end
          else
          begin
            state   <= st_idle;
            bit_cnt <= '0;
          end
        end

        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/sample_ring.sv
////////////////////
// circular byte buffer for kept samples
// write pointer wraps at buf_len, host read is registered
////////////////////
`timescale 1ns/1ps
`default_nettype none

module sample_ring import accel_log_pkg::*; #(
  parameter  int buf_len = 6144,
  localparam int addr_w  = $clog2(buf_len)
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              wr_en,
  input  byte_t             wr_data,
  input  logic [addr_w-1:0] rd_addr,
  output byte_t             rd_data,
  output logic [addr_w-1:0] wr_ptr
);

  byte_t mem [buf_len]; // no reset on storage

  // write side
  always_ff @(posedge clk)
  begin
    if (rst)
      wr_ptr <= '0;
    else if (wr_en)
    begin
      if (wr_ptr == addr_w'(buf_len - 1))
        wr_ptr <= '0; // wrap
      else
        wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= wr_data;
    rd_data <= mem[rd_addr]; // one cycle latency
  end

endmodule

`default_nettype wire

//--- hw/accel_logger_top.sv
////////////////////
// accelerometer logger top
// pps disciplined sync, spi reader, sample ring with host read port
////////////////////
`timescale 1ns/1ps
`default_nettype none

module accel_logger_top import accel_log_pkg::*; #(
  parameter  int    clk_hz     = 40_000_000,
  parameter  int    sync_hz    = 1000,       // sample rate
  parameter  int    pps_period = 40_000_000, // clocks per pps
  parameter  int    pps_tol    = 20_000,
  parameter  int    pa_bits    = 30,
  parameter  int    data_len   = 9,          // 3 axes x 3 bytes
  parameter  byte_t cmd        = 8'h11,
  parameter  int    buf_len    = 6144,
  localparam int    addr_w     = $clog2(buf_len)
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              pps,
  input  logic              miso,
  output spi_pins_t         spi,
  output logic              sync,    // to sensor sync pin
  output sync_status_t      status,
  input  logic [addr_w-1:0] rd_addr,
  output byte_t             rd_data,
  output logic [addr_w-1:0] wr_ptr
);

  logic  wr_en;
  byte_t wr_data;

  sync_gen #(
    .clk_hz     (clk_hz),
    .sync_hz    (sync_hz),
    .pps_period (pps_period),
    .pps_tol    (pps_tol),
    .pa_bits    (pa_bits)
  ) u_sync_gen (
    .clk    (clk),
    .rst    (rst),
    .pps    (pps),
    .sync   (sync),
    .status (status)
  );

  accel_spi_reader #(
    .cmd      (cmd),
    .data_len (data_len)
  ) u_spi_reader (
    .clk     (clk),
    .rst     (rst),
    .sync    (sync),
    .miso    (miso),
    .pins    (spi),
    .busy    (),      // observed by bound checks only
    .wr_en   (wr_en),
    .wr_data (wr_data)
  );

  sample_ring #(
    .buf_len (buf_len)
  ) u_ring (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_ptr  (wr_ptr)
  );

endmodule

`default_nettype wire

//--- sim/accel_logger_asserts.sv
////////////////////
// bound checks on spi pins, write strobe and sync width
// bound into the spi reader, whose sync input is the generator strobe
////////////////////
`timescale 1ns/1ps
`default_nettype none

module accel_logger_asserts (
  input wire logic clk,
  input wire logic rst,
  input wire logic csn,
  input wire logic sclk,
  input wire logic busy,
  input wire logic wr_en,
  input wire logic sync
);

  int fail_cnt = 0; // read by the testbench

  // mode 3 clock idles high outside a transfer
  sclk_idle: assert property (@(posedge clk) disable iff (rst) csn |-> sclk)
    else
    begin
      $error("sclk low while csn high");
      fail_cnt++;
    end

  wr_busy: assert property (@(posedge clk) disable iff (rst) wr_en |-> busy)
    else
    begin
      $error("wr_en outside transfer");
      fail_cnt++;
    end

  // strobe is a single cycle
  sync_pulse: assert property (@(posedge clk) disable iff (rst) sync |=> !sync)
    else
    begin
      $error("sync wider than one cycle");
      fail_cnt++;
    end

endmodule

bind accel_spi_reader accel_logger_asserts spi_chk (
  .clk(clk), .rst(rst), .csn(pins.csn), .sclk(pins.sclk),
  .busy(busy), .wr_en(wr_en), .sync(sync)
);

`default_nettype wire

//--- sim/accel_logger_tb.sv
////////////////////
// testbench for the accelerometer logger
// pps and host stimulus, sensor spi model, kept byte model
////////////////////
`timescale 1ns/1ps
`default_nettype none

module accel_logger_tb import accel_log_pkg::*;;

  localparam int    clk_hz     = 1000;
  localparam int    sync_hz    = 10;
  localparam int    pps_period = 1000;
  localparam int    pps_tol    = 20;
  localparam int    pa_bits    = 16;
  localparam int    data_len   = 9;
  localparam byte_t cmd        = 8'h11;
  localparam int    buf_len    = 64;
  localparam int    addr_w     = $clog2(buf_len);
  localparam int    n_pps      = 13;
  localparam int    step       = sync_hz * (1 << pa_bits) / clk_hz;
  localparam int    wrap_cycles = ((1 << pa_bits) + step - 1) / step;
  localparam int    exp_delay  = 3 + wrap_cycles; // two sync flops, edge reg, then first wrap
  localparam int    exp_count  = sync_hz * pps_period / clk_hz;
  localparam int    kept_per_xfer = data_len * 2 / 3;
  localparam int    timeout_cycles = (n_pps + 2) * pps_period + 2000;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  logic              pps = 1'b0;
  logic              miso = 1'b0;
  logic [addr_w-1:0] rd_addr = '0;
  spi_pins_t         spi;
  logic              sync;
  sync_status_t      status;
  byte_t             rd_data;
  logic [addr_w-1:0] wr_ptr;

  int err_reset = 0;
  int err_spi   = 0;
  int err_data  = 0;
  int err_pps   = 0;
  int err_other = 0;
  int cycles    = 0;
  int xfers     = 0;
  int checked   = 0; // bytes read back and compared
  int kept_total = 0; // kept bytes sent by the sensor
  byte_t kept_q[$];  // model of bytes still to be stored

  accel_logger_top #(
    .clk_hz(clk_hz), .sync_hz(sync_hz), .pps_period(pps_period), .pps_tol(pps_tol),
    .pa_bits(pa_bits), .data_len(data_len), .cmd(cmd), .buf_len(buf_len)
  ) dut_i (
    .clk(clk), .rst(rst), .pps(pps), .miso(miso), .spi(spi), .sync(sync),
    .status(status), .rd_addr(rd_addr), .rd_data(rd_data), .wr_ptr(wr_ptr)
  );

  initial
  begin
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > timeout_cycles)
    begin
      $display("timeout after %0d cycles, the pps sequence never completed", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
  endtask

  // sensor model, mode 3
  wire   csn_w  = spi.csn;
  wire   sclk_w = spi.sclk;
  wire   mosi_w = spi.mosi;
  int    rise_cnt = 0;
  int    fall_idx = 0;
  bit    in_xfer = 0;
  byte_t cmd_cap;
  byte_t cur_byte;

  always @(negedge csn_w)
  begin
    in_xfer  = 1;
    rise_cnt = 0;
    fall_idx = 0;
    cmd_cap  = '0;
  end

  always @(posedge sclk_w)
  begin
    if (!csn_w)
    begin
      if (rise_cnt < 8)
        cmd_cap = {cmd_cap[6:0], mosi_w}; // command msb first
      rise_cnt++;
    end
  end

  always @(negedge sclk_w)
  begin
    if (!csn_w && rise_cnt >= 8)
    begin
      #1;
      if (fall_idx % 8 == 0)
      begin
        cur_byte = byte_t'($urandom);
        if ((fall_idx / 8) % 3 != 2) // third byte of each axis is dropped
        begin
          kept_q.push_back(cur_byte);
          kept_total++;
        end
      end
      miso = cur_byte[7 - fall_idx % 8];
      fall_idx++;
    end
  end

  always @(posedge csn_w)
  begin
    if (in_xfer)
    begin
      in_xfer = 0;
      xfers++;
      if (cmd_cap !== cmd)
      begin
        report_mismatch("cmd_bits", int'(cmd_cap), int'(cmd));
        err_spi++;
      end
      if (rise_cnt != 8 + 8 * data_len)
      begin
        report_mismatch("sclk_rises", rise_cnt, 8 + 8 * data_len);
        err_spi++;
      end
      #1; // sample clear of the clock edge
      if (int'(wr_ptr) != kept_total % buf_len)
      begin
        report_mismatch("wr_ptr", int'(wr_ptr), kept_total % buf_len);
        err_data++;
      end
    end
  end

  // read back each stored byte right after its write
  logic [addr_w-1:0] last_ptr = '0;
  logic [addr_w-1:0] wr_addr;
  byte_t             exp_byte;

  always @(posedge clk)
  begin
    #1;
    if (!rst && wr_ptr != last_ptr)
    begin
      wr_addr  = last_ptr;
      last_ptr = wr_ptr;
      checked++;
      rd_addr = wr_addr;
      @(posedge clk);
      #1;
      if (kept_q.size() == 0)
      begin
        $display("ring stored a byte at t=%0t that the sensor never sent", $time);
        err_data++;
      end
      else
      begin
        exp_byte = kept_q.pop_front();
        if (rd_data !== exp_byte)
        begin
          report_mismatch("rd_data", int'(rd_data), int'(exp_byte));
          err_data++;
        end
      end
    end
  end

  // raise pps now, hold gap cycles, and time the first new-phase sync
  task automatic pps_edge(input int gap, output int delay);
    int n;
    pps   = 1'b1;
    delay = -1;
    for (n = 1; n < gap; n++)
    begin
      @(posedge clk);
      #1;
      if (n == 10)
        pps = 1'b0;
      if (n > 3 && delay < 0 && sync) // earlier strobes belong to the old phase
        delay = n;
    end
    @(posedge clk);
    #1;
  endtask

  int  gaps [n_pps];
  int  delay;
  int  k;
  int  ivl;
  bit  valid;
  bit  valid_prev;
  int  asrt_fails;
  int  total;

  initial
  begin
    void'($urandom(11));
    for (k = 0; k < n_pps; k++)
      gaps[k] = pps_period;
    gaps[3] = pps_period + 550; // far out, breaks lock, old phase off by half a strobe
    for (k = 6; k < n_pps - 1; k++)
      gaps[k] = pps_period - (pps_tol - 2) + $urandom_range(2 * (pps_tol - 2));

    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    if (spi.csn !== 1'b1 || spi.sclk !== 1'b1)
    begin
      report_mismatch("csn_sclk", int'({spi.csn, spi.sclk}), 3);
      err_reset++;
    end
    if (sync !== 1'b0)
    begin
      report_mismatch("sync", int'(sync), 0);
      err_reset++;
    end
    if (wr_ptr !== '0)
    begin
      report_mismatch("wr_ptr", int'(wr_ptr), 0);
      err_reset++;
    end
    if (status !== '0)
    begin
      report_mismatch("status", int'(status), 0);
      err_reset++;
    end

    repeat (300) @(posedge clk); // first edge too early to be valid
    #1;
    valid_prev = 0;
    for (k = 0; k < n_pps; k++)
    begin
      pps_edge(gaps[k], delay);
      ivl   = (k == 0) ? 0 : gaps[k-1];
      valid = (k > 0) && (ivl >= pps_period - pps_tol) && (ivl <= pps_period + pps_tol);
      if (status.pps_valid !== valid)
      begin
        report_mismatch("pps_valid", int'(status.pps_valid), int'(valid));
        err_pps++;
      end
      if (status.locked !== (valid & valid_prev))
      begin
        report_mismatch("locked", int'(status.locked), int'(valid & valid_prev));
        err_pps++;
      end
      if (valid && (int'(status.sync_count) < exp_count - 1 ||
                    int'(status.sync_count) > exp_count + 1))
      begin
        report_mismatch("sync_count", int'(status.sync_count), exp_count);
        err_pps++;
      end
      if (valid && delay != exp_delay)
      begin
        report_mismatch("sync_delay", delay, exp_delay);
        err_pps++;
      end
      if (!valid && k > 0 && delay == exp_delay)
      begin
        $display("phase realigned on an out of tolerance pps edge at t=%0t", $time);
        err_pps++;
      end
      valid_prev = valid;
    end

    if (xfers < cycles / (3 * wrap_cycles))
    begin
      $display("only %0d spi transfers seen in %0d cycles", xfers, cycles);
      err_other++;
    end
    if (checked < (xfers - 1) * kept_per_xfer)
    begin
      $display("only %0d bytes stored for %0d transfers", checked, xfers);
      err_other++;
    end

    asrt_fails = dut_i.u_spi_reader.spi_chk.fail_cnt;
    total = err_reset + err_spi + err_data + err_pps + err_other + asrt_fails;
    $display("errors: reset=%0d spi=%0d data=%0d pps=%0d other=%0d assert=%0d total=%0d",
             err_reset, err_spi, err_data, err_pps, err_other, asrt_fails, total);
    if (total == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
hw/accel_log_pkg.sv
hw/sync_gen.sv
hw/accel_spi_reader.sv
hw/sample_ring.sv
hw/accel_logger_top.sv
sim/accel_logger_asserts.sv
sim/accel_logger_tb.sv

//--- Makefile
# verilator build and run of the accelerometer logger testbench

SIM = obj_dir/Vaccel_logger_tb

.PHONY: all run clean

all: run

$(SIM): flist.f $(wildcard hw/*.sv sim/*.sv)
	verilator --binary --timing --assert -j 0 --top-module accel_logger_tb -f flist.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
